// ==== flist.f ====
hw/backend_pkg.sv
hw/ds_stage.sv
hw/int_rs.sv
hw/cdb_arbiter.sv
hw/rob.sv
hw/backend_top.sv
test/backend_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile the backend testbench with Verilator, run it and scan the log
set -u

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --top-module backend_tb -Mdir obj_dir -f flist.f > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$build_log"
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/Vbackend_tb > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$sim_log"; then
    exit 1
fi
exit 0

// ==== test/backend_tb.sv ====
`timescale 1ns/100ps

module backend_tb;

    localparam int ROB_DEPTH  = 8;
    localparam int N_LI       = 8;
    localparam int N_CHAIN    = 300;
    localparam int N_BURST    = 6;
    localparam int BURST_LEN  = 12;
    localparam int N_UOPS     = N_LI + N_CHAIN + N_BURST * BURST_LEN;
    localparam int MAX_CYCLES = 20 * N_UOPS + 100;

    logic                   clk;
    logic                   rst_n_i;
    logic                   in_valid_i;
    backend_pkg::uop_in_t   in_uop_i;
    logic                   in_ready_o;
    logic                   commit_valid_o;
    backend_pkg::commit_t   commit_o;

    logic [31:0]            rng_state = 32'h8ed7_1899;
    logic [31:0]            model_reg [8] = '{default: 32'h0};    // architectural state
    backend_pkg::commit_t   exp_q [$];
    int                     acc_cnt = 0;
    int                     com_cnt = 0;
    int                     cycle_cnt = 0;
    logic                   taken = 1'b0;    // offer on the bus is taken at the next edge
    string                  test_name = "reset";

    backend_top uut (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .in_valid_i     (in_valid_i),
        .in_uop_i       (in_uop_i),
        .in_ready_o     (in_ready_o),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // mostly the low half of the register file, so readers hit recent writers often
    function automatic logic [2:0] pick_reg();
        logic [31:0] r;
        r = next_rand();
        if (r[4:3] == 2'b00) begin
            return r[2:0];
        end
        return {1'b0, r[1:0]};
    endfunction

    function automatic backend_pkg::op_e pick_alu_op();
        logic [31:0] r;
        r = next_rand();
        return backend_pkg::op_e'(3'(r % 5) + 3'd1);    // ADD through XOR
    endfunction

    function automatic logic [31:0] model_alu(backend_pkg::op_e op, logic [31:0] a,
                                              logic [31:0] b, logic [15:0] imm);
        case (op)
            backend_pkg::OP_LI:  return {16'h0000, imm};
            backend_pkg::OP_ADD: return a + b;
            backend_pkg::OP_SUB: return a - b;
            backend_pkg::OP_AND: return a & b;
            backend_pkg::OP_OR:  return a | b;
            backend_pkg::OP_XOR: return a ^ b;
            default:             return 32'h0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            $display("Something failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic send_uop(input backend_pkg::uop_in_t u);
        in_valid_i <= 1'b1;
        in_uop_i   <= u;
        @(posedge clk);
        while (!taken) begin
            @(posedge clk);
        end
    endtask

    task automatic idle_cycle();
        in_valid_i <= 1'b0;
        @(posedge clk);
    endtask

    task automatic wait_drain();
        in_valid_i <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    // *******************************************************************
    // the monitor samples mid-cycle while everything is stable
    // *******************************************************************
    always @(negedge clk) begin : monitor
        backend_pkg::commit_t exp_c;
        backend_pkg::uop_in_t u;
        logic [31:0]          v;
        if (!rst_n_i) begin
            taken = 1'b0;
        end else begin
            check_value("occupancy_bound", 32'd1, 32'(acc_cnt - com_cnt <= ROB_DEPTH));
            if (acc_cnt - com_cnt == ROB_DEPTH) begin
                check_value("ready_when_full", 32'd0, 32'(in_ready_o));
            end
            if (commit_valid_o) begin
                if (exp_q.size() == 0) begin
                    $display("a commit came out with no accepted uop waiting for it");
                    $display("Something failed");
                    $fatal(1, "unexpected commit");
                end else begin
                    exp_c = exp_q.pop_front();
                    check_value({test_name, "_rd"}, 32'(exp_c.rd), 32'(commit_o.rd));
                    check_value({test_name, "_value"}, exp_c.value, commit_o.value);
                    com_cnt++;
                end
            end
            taken = in_valid_i && in_ready_o;
            if (taken) begin
                u = in_uop_i;
                v = model_alu(u.op, model_reg[u.rs1], model_reg[u.rs2], u.imm);
                model_reg[u.rd] = v;    // program order, one uop at a time
                exp_c.rd    = u.rd;
                exp_c.value = v;
                exp_q.push_back(exp_c);
                acc_cnt++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    // *******************************************************************
    // stimulus
    // *******************************************************************
    initial begin : stimulus
        logic [31:0]          r;
        backend_pkg::uop_in_t u;
        rst_n_i    = 1'b0;
        in_valid_i = 1'b0;
        in_uop_i   = '0;
        repeat (4) @(posedge clk);
        rst_n_i <= 1'b1;
        repeat (5) begin
            @(negedge clk);
            check_value("reset_ready", 32'd1, 32'(in_ready_o));
            check_value("reset_commit", 32'd0, 32'(commit_valid_o));
        end
        @(posedge clk);

        test_name = "li";
        for (int i = 0; i < N_LI; i++) begin
            r     = next_rand();
            u.op  = backend_pkg::OP_LI;
            u.rd  = 3'(i);
            u.rs1 = r[18:16];    // ignored by LI
            u.rs2 = r[21:19];
            u.imm = r[15:0];
            send_uop(u);
        end
        wait_drain();

        test_name = "chain";
        for (int i = 0; i < N_CHAIN; i++) begin
            if (next_rand() % 4 == 0) begin
                idle_cycle();
            end
            u.op  = pick_alu_op();
            u.rd  = pick_reg();
            u.rs1 = pick_reg();
            u.rs2 = pick_reg();
            u.imm = 16'(next_rand());
            send_uop(u);
        end
        wait_drain();

        // writes go to r0..r3 and reads come from r4..r7, so nothing waits on a producer
        test_name = "burst";
        for (int b = 0; b < N_BURST; b++) begin
            for (int i = 0; i < BURST_LEN; i++) begin
                r     = next_rand();
                u.op  = pick_alu_op();
                u.rd  = {1'b0, r[1:0]};
                u.rs1 = {1'b1, r[3:2]};
                u.rs2 = {1'b1, r[5:4]};
                u.imm = r[21:6];
                send_uop(u);
            end
            repeat (2) idle_cycle();
        end
        wait_drain();

        $display("Everything OK");
        $finish;
    end

endmodule

// ==== hw/backend_top.sv ====
`timescale 1ns/100ps

module backend_top #(
    parameter int NUM_LANES = 3,
    parameter int RS_DEPTH  = 4,
    parameter int ROB_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    in_valid_i,
    input  backend_pkg::uop_in_t    in_uop_i,
    output logic                    in_ready_o,
    output logic                    commit_valid_o,
    output backend_pkg::commit_t    commit_o
);

    logic [NUM_LANES-1:0]                   lane_free;
    logic [NUM_LANES-1:0]                   lane_disp;
    logic [NUM_LANES-1:0]                   lane_grant;
    backend_pkg::cdb_t [NUM_LANES-1:0]      lane_req;
    backend_pkg::rs_entry_t                 disp_entry;
    backend_pkg::cdb_t                      cdb;    // single result bus for everyone
    logic                                   rob_full;
    logic                                   alloc;
    logic [backend_pkg::TAG_W-1:0]          alloc_tag;
    logic [1:0][backend_pkg::TAG_W-1:0]     rd_tag;
    backend_pkg::rob_rd_t [1:0]             rob_rd;

    ds_stage #(
        .NUM_LANES          (NUM_LANES)
    ) ds_stage_i (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .in_valid_i         (in_valid_i),
        .in_uop_i           (in_uop_i),
        .lane_free_i        (lane_free),
        .rob_full_i         (rob_full),
        .alloc_tag_i        (alloc_tag),
        .rob_rd_i           (rob_rd),
        .cdb_i              (cdb),
        .commit_valid_i     (commit_valid_o),
        .commit_i           (commit_o),
        .in_ready_o         (in_ready_o),
        .disp_o             (lane_disp),
        .disp_entry_o       (disp_entry),
        .alloc_o            (alloc),
        .rd_tag_o           (rd_tag)
    );

    rob #(
        .ROB_DEPTH          (ROB_DEPTH)
    ) rob_i (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .alloc_i            (alloc),
        .alloc_rd_i         (in_uop_i.rd),
        .rd_tag_i           (rd_tag),
        .cdb_i              (cdb),
        .rob_full_o         (rob_full),
        .alloc_tag_o        (alloc_tag),
        .rd_data_o          (rob_rd),
        .commit_valid_o     (commit_valid_o),
        .commit_o           (commit_o)
    );

    // identical integer lanes, each with its own ALU
    generate
        for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
            int_rs #(
                .RS_DEPTH       (RS_DEPTH)
            ) int_rs_i (
                .clk            (clk),
                .rst_n_i        (rst_n_i),
                .disp_i         (lane_disp[l]),
                .disp_entry_i   (disp_entry),
                .cdb_i          (cdb),
                .grant_i        (lane_grant[l]),
                .free_o         (lane_free[l]),
                .req_o          (lane_req[l])
            );
        end
    endgenerate

    cdb_arbiter #(
        .NUM_LANES          (NUM_LANES)
    ) cdb_arbiter_i (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .req_i              (lane_req),
        .grant_o            (lane_grant),
        .cdb_o              (cdb)
    );

endmodule

// ==== hw/rob.sv ====
`timescale 1ns/100ps

module rob #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                alloc_i,
    input  logic [backend_pkg::REG_W-1:0]       alloc_rd_i,
    input  logic [1:0][backend_pkg::TAG_W-1:0]  rd_tag_i,
    input  backend_pkg::cdb_t                   cdb_i,
    output logic                                rob_full_o,
    output logic [backend_pkg::TAG_W-1:0]       alloc_tag_o,
    output backend_pkg::rob_rd_t [1:0]          rd_data_o,
    output logic                                commit_valid_o,
    output backend_pkg::commit_t                commit_o
);

    localparam int IDX_W = $clog2(ROB_DEPTH);
    localparam int CNT_W = IDX_W + 1;

    logic [backend_pkg::REG_W-1:0]  rd_q  [ROB_DEPTH];
    logic [backend_pkg::XLEN-1:0]   val_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0]           done_q;
    logic [IDX_W-1:0]               head_q;
    logic [IDX_W-1:0]               tail_q;
    logic [CNT_W-1:0]               cnt_q;
    logic [CNT_W-1:0]               live;
    logic [IDX_W-1:0]               cdb_idx;
    logic                           head_done;

    // a slot stays counted until its commit pulse has gone out
    assign rob_full_o = (cnt_q == CNT_W'(ROB_DEPTH));
    assign cdb_idx    = cdb_i.tag[IDX_W-1:0];
    assign live       = cnt_q - CNT_W'(commit_valid_o);    // entries not yet retired
    assign head_done  = (live != '0) && done_q[head_q];

    always_comb begin
        alloc_tag_o             = '0;
        alloc_tag_o[IDX_W-1:0]  = tail_q;
        for (int s = 0; s < 2; s++) begin
            rd_data_o[s] = '{done:  done_q[rd_tag_i[s][IDX_W-1:0]],
                             value: val_q[rd_tag_i[s][IDX_W-1:0]]};
        end
    end

    // ******************************************************************
    // pointers, occupancy and completion
    // ******************************************************************
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q         <= '0;
            tail_q         <= '0;
            cnt_q          <= '0;
            done_q         <= '0;
            commit_valid_o <= 1'b0;
        end else begin
            commit_valid_o <= head_done;
            cnt_q          <= cnt_q + CNT_W'(alloc_i) - CNT_W'(commit_valid_o);
            if (alloc_i) begin
                tail_q         <= tail_q + 1'b1;    // depth is a power of two, wraps by itself
                done_q[tail_q] <= 1'b0;
            end
            if (cdb_i.valid) begin
                done_q[cdb_idx] <= 1'b1;
            end
            if (head_done) begin
                head_q <= head_q + 1'b1;
            end
        end
    end

    // a retired slot keeps its value readable until it is allocated again
    always_ff @(posedge clk) begin
        if (alloc_i) begin
            rd_q[tail_q] <= alloc_rd_i;
        end
        if (cdb_i.valid) begin
            val_q[cdb_idx] <= cdb_i.value;
        end
        if (head_done) begin
            commit_o <= '{rd: rd_q[head_q], value: val_q[head_q]};
        end
    end

endmodule

// ==== hw/cdb_arbiter.sv ====
`timescale 1ns/100ps

module cdb_arbiter #(
    parameter int NUM_LANES = 3
) (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  backend_pkg::cdb_t [NUM_LANES-1:0]   req_i,
    output logic [NUM_LANES-1:0]                grant_o,
    output backend_pkg::cdb_t                   cdb_o
);

    localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [PTR_W-1:0]   ptr_q;
    logic [PTR_W-1:0]   win;
    logic               found;

    // scan from the pointer around the ring, first valid lane wins the bus
    always_comb begin
        int idx;
        grant_o = '0;
        cdb_o   = '0;
        found   = 1'b0;
        win     = ptr_q;
        for (int k = 0; k < NUM_LANES; k++) begin
            idx = int'(ptr_q) + k;
            if (idx >= NUM_LANES) begin
                idx = idx - NUM_LANES;
            end
            if (!found && req_i[idx].valid) begin
                found        = 1'b1;
                win          = PTR_W'(idx);
                grant_o[idx] = 1'b1;
                cdb_o        = req_i[idx];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ptr_q <= '0;
        end else if (found) begin
            ptr_q <= (win == PTR_W'(NUM_LANES - 1)) ? '0 : win + 1'b1;    // winner goes last
        end
    end

endmodule

// ==== hw/int_rs.sv ====
`timescale 1ns/100ps

module int_rs #(
    parameter int RS_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    disp_i,
    input  backend_pkg::rs_entry_t  disp_entry_i,
    input  backend_pkg::cdb_t       cdb_i,
    input  logic                    grant_i,
    output logic                    free_o,
    output backend_pkg::cdb_t       req_o
);

    localparam int AGE_W = $clog2(RS_DEPTH + 1);
    localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;

    backend_pkg::rs_entry_t         slot_q [RS_DEPTH];
    logic [AGE_W-1:0]               age_q  [RS_DEPTH];    // number of younger live entries
    logic [RS_DEPTH-1:0]            valid_q;
    logic [IDX_W-1:0]               ins_idx;
    logic [IDX_W-1:0]               iss_idx;
    logic                           iss_found;
    logic                           issue;
    backend_pkg::rs_entry_t         iss_e;
    logic [backend_pkg::XLEN-1:0]   alu_res;
    backend_pkg::cdb_t              res_q;

    function automatic backend_pkg::operand_t wake(backend_pkg::operand_t op,
                                                   backend_pkg::cdb_t bus);
        wake = op;
        if (!op.ready && bus.valid && bus.tag == op.tag) begin
            wake.ready = 1'b1;
            wake.value = bus.value;
        end
    endfunction

    assign free_o = !(&valid_q);
    assign req_o  = res_q;

    always_comb begin
        ins_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                ins_idx = IDX_W'(i);
            end
        end
    end

    // oldest ready entry has the largest age
    always_comb begin
        iss_found = 1'b0;
        iss_idx   = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (valid_q[i] && slot_q[i].src1.ready && slot_q[i].src2.ready &&
                (!iss_found || age_q[i] > age_q[iss_idx])) begin
                iss_found = 1'b1;
                iss_idx   = IDX_W'(i);
            end
        end
    end

    assign issue = iss_found && (!res_q.valid || grant_i);    // held result blocks issue
    assign iss_e = slot_q[iss_idx];

    always_comb begin
        unique case (iss_e.op)
            backend_pkg::OP_LI:  alu_res = {{(backend_pkg::XLEN - 16){1'b0}}, iss_e.imm};
            backend_pkg::OP_ADD: alu_res = iss_e.src1.value + iss_e.src2.value;
            backend_pkg::OP_SUB: alu_res = iss_e.src1.value - iss_e.src2.value;
            backend_pkg::OP_AND: alu_res = iss_e.src1.value & iss_e.src2.value;
            backend_pkg::OP_OR:  alu_res = iss_e.src1.value | iss_e.src2.value;
            backend_pkg::OP_XOR: alu_res = iss_e.src1.value ^ iss_e.src2.value;
            default:             alu_res = '0;
        endcase
    end

    // ******************************************************************
    // slot occupancy and ages
    // ******************************************************************
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
            for (int i = 0; i < RS_DEPTH; i++) begin
                age_q[i] <= '0;
            end
        end else begin
            // a new entry ages everyone, a leaving entry un-ages the older ones
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (valid_q[i]) begin
                    age_q[i] <= age_q[i] + AGE_W'(disp_i)
                              - AGE_W'(issue && age_q[i] > age_q[iss_idx]);
                end
            end
            if (issue) begin
                valid_q[iss_idx] <= 1'b0;
            end
            if (disp_i) begin
                valid_q[ins_idx] <= 1'b1;
                age_q[ins_idx]   <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (valid_q[i]) begin
                slot_q[i].src1 <= wake(slot_q[i].src1, cdb_i);
                slot_q[i].src2 <= wake(slot_q[i].src2, cdb_i);
            end
        end
        if (disp_i) begin
            slot_q[ins_idx] <= disp_entry_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_q <= '0;
        end else if (issue) begin
            res_q <= '{valid: 1'b1, tag: iss_e.tag, value: alu_res};
        end else if (grant_i) begin
            res_q.valid <= 1'b0;
        end
    end

endmodule

// ==== hw/ds_stage.sv ====
`timescale 1ns/100ps

module ds_stage #(
    parameter int NUM_LANES = 3
) (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                in_valid_i,
    input  backend_pkg::uop_in_t                in_uop_i,
    input  logic [NUM_LANES-1:0]                lane_free_i,
    input  logic                                rob_full_i,
    input  logic [backend_pkg::TAG_W-1:0]       alloc_tag_i,
    input  backend_pkg::rob_rd_t [1:0]          rob_rd_i,
    input  backend_pkg::cdb_t                   cdb_i,
    input  logic                                commit_valid_i,
    input  backend_pkg::commit_t                commit_i,
    output logic                                in_ready_o,
    output logic [NUM_LANES-1:0]                disp_o,
    output backend_pkg::rs_entry_t              disp_entry_o,
    output logic                                alloc_o,
    output logic [1:0][backend_pkg::TAG_W-1:0]  rd_tag_o
);

    // wide enough to count every ROB slot writing the same register
    localparam int CNT_W = $clog2(backend_pkg::ROB_DEPTH_MAX) + 1;

    logic [CNT_W-1:0]                   pend_cnt [backend_pkg::ARCH_REGS];
    logic [backend_pkg::TAG_W-1:0]      rat_tag  [backend_pkg::ARCH_REGS];
    logic [backend_pkg::XLEN-1:0]       arf      [backend_pkg::ARCH_REGS];
    logic [backend_pkg::ARCH_REGS-1:0]  wr_hit;
    logic [backend_pkg::ARCH_REGS-1:0]  cm_hit;
    logic [backend_pkg::REG_W-1:0]      src_reg  [2];
    backend_pkg::operand_t              src_op   [2];
    logic                               accept;

    assign in_ready_o = !rob_full_i && (|lane_free_i);
    assign accept     = in_valid_i && in_ready_o;
    assign alloc_o    = accept;

    // lowest set bit of the free vector picks the lane
    assign disp_o = accept ? (lane_free_i & (~lane_free_i + 1'b1)) : '0;

    // ******************************************************************
    // an operand takes the first hit in ARF, ROB and same-cycle CDB order or waits
    // ******************************************************************
    always_comb begin
        src_reg[0] = in_uop_i.rs1;
        src_reg[1] = in_uop_i.rs2;
        for (int s = 0; s < 2; s++) begin
            rd_tag_o[s]   = rat_tag[src_reg[s]];
            src_op[s].tag = rat_tag[src_reg[s]];
            if (in_uop_i.op == backend_pkg::OP_LI || pend_cnt[src_reg[s]] == '0) begin
                src_op[s].ready = 1'b1;    // LI never waits on its register fields
                src_op[s].value = arf[src_reg[s]];
            end else if (rob_rd_i[s].done) begin
                src_op[s].ready = 1'b1;
                src_op[s].value = rob_rd_i[s].value;
            end else if (cdb_i.valid && cdb_i.tag == rat_tag[src_reg[s]]) begin
                src_op[s].ready = 1'b1;
                src_op[s].value = cdb_i.value;
            end else begin
                src_op[s].ready = 1'b0;
                src_op[s].value = '0;
            end
        end
    end

    assign disp_entry_o = '{
        op:   in_uop_i.op,
        tag:  alloc_tag_i,
        src1: src_op[0],
        src2: src_op[1],
        imm:  in_uop_i.imm
    };

    always_comb begin
        for (int r = 0; r < backend_pkg::ARCH_REGS; r++) begin
            wr_hit[r] = accept && (int'(in_uop_i.rd) == r);
            cm_hit[r] = commit_valid_i && (int'(commit_i.rd) == r);
        end
    end

    // ******************************************************************
    // rename table and architectural registers
    // ******************************************************************

    // an entry stays live while writers of the register are in flight and goes empty
    // only when the committing writer is the youngest one that still holds the mapped tag
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int r = 0; r < backend_pkg::ARCH_REGS; r++) begin
                pend_cnt[r] <= '0;
                arf[r]      <= '0;
            end
        end else begin
            for (int r = 0; r < backend_pkg::ARCH_REGS; r++) begin
                if (wr_hit[r] && !cm_hit[r]) begin
                    pend_cnt[r] <= pend_cnt[r] + 1'b1;
                end else if (!wr_hit[r] && cm_hit[r]) begin
                    pend_cnt[r] <= pend_cnt[r] - 1'b1;
                end
                if (cm_hit[r]) begin
                    arf[r] <= commit_i.value;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rat_tag[in_uop_i.rd] <= alloc_tag_i;    // youngest writer takes the mapping
        end
    end

endmodule

// ==== hw/backend_pkg.sv ====
package backend_pkg;

    localparam int ARCH_REGS     = 8;
    localparam int REG_W         = $clog2(ARCH_REGS);
    localparam int XLEN          = 32;
    localparam int ROB_DEPTH_MAX = 16;
    localparam int TAG_W         = $clog2(ROB_DEPTH_MAX);    // a tag is the ROB index

    typedef enum logic [2:0] {
        OP_LI  = 3'd0,
        OP_ADD = 3'd1,
        OP_SUB = 3'd2,
        OP_AND = 3'd3,
        OP_OR  = 3'd4,
        OP_XOR = 3'd5
    } op_e;

    typedef struct packed {
        op_e                op;
        logic [REG_W-1:0]   rd;
        logic [REG_W-1:0]   rs1;
        logic [REG_W-1:0]   rs2;
        logic [15:0]        imm;
    } uop_in_t;

    // ready clear means value is not valid yet and tag names the producer
    typedef struct packed {
        logic               ready;
        logic [TAG_W-1:0]   tag;
        logic [XLEN-1:0]    value;
    } operand_t;

    typedef struct packed {
        op_e                op;
        logic [TAG_W-1:0]   tag;     // destination ROB slot
        operand_t           src1;
        operand_t           src2;
        logic [15:0]        imm;
    } rs_entry_t;

    typedef struct packed {
        logic               valid;
        logic [TAG_W-1:0]   tag;
        logic [XLEN-1:0]    value;
    } cdb_t;

    typedef struct packed {
        logic               done;
        logic [XLEN-1:0]    value;
    } rob_rd_t;

    typedef struct packed {
        logic [REG_W-1:0]   rd;
        logic [XLEN-1:0]    value;
    } commit_t;

endpackage
